//--- Makefile
LOG := sim.log
SIM := obj_dir/Vtb_hilo_writeback

.PHONY: all run lint clean

all: run

$(SIM): sources.f common/hilo_config.svh common/hilo_pkg.sv hilo/*.sv tb/*.sv
	verilator --binary --timing --assert -f sources.f \
		--top-module tb_hilo_writeback -o Vtb_hilo_writeback

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module hilo_writeback
	verilator --lint-only -Wall --timing -f sources.f --top-module tb_hilo_writeback

clean:
	rm -rf obj_dir $(LOG)

//--- common/hilo_config.svh
`ifndef HILO_CONFIG_SVH
`define HILO_CONFIG_SVH

// width of one data word
// HI and LO are one word each
`define HILO_WORD_W 32

// retiring slots per cycle
// slot 1 is the older instruction, slot 0 the younger
`define HILO_SLOTS 2

// HI and LO after reset
`define HILO_RESET_VAL {`HILO_WORD_W{1'b0}}

`endif

//--- common/hilo_pkg.sv
`default_nettype none

`include "hilo_config.svh"

package hilo_pkg;

    typedef logic [`HILO_WORD_W-1:0]   word_t;
    typedef logic [2*`HILO_WORD_W-1:0] dword_t;

    // operations that retire into HI/LO
    typedef enum logic [2:0] {
        HILO_NOP  = 3'd0,
        HILO_MTHI = 3'd1,
        HILO_MTLO = 3'd2,
        HILO_MULT = 3'd3,
        HILO_MADD = 3'd4,
        HILO_MSUB = 3'd5
    } hilo_op_t;

    // one retiring instruction as it leaves the memory stages
    typedef struct packed {
        logic     valid;
        hilo_op_t op;
        word_t    srca;
        dword_t   product;
    } retire_slot_t;

    // decoded write controls for one slot
    typedef struct packed {
        logic   hi_write;
        logic   lo_write;
        logic   from_srca;
        logic   accum_add;
        logic   accum_sub;
        word_t  srca;
        dword_t product;
    } hilo_ctl_t;

    // merged write into the HI/LO registers
    typedef struct packed {
        logic  hi_we;
        logic  lo_we;
        word_t hi_data;
        word_t lo_data;
    } hilo_update_t;

endpackage

`default_nettype wire

//--- hilo/hilo_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "hilo_config.svh"

module hilo_decode (
    input  wire logic                                 clk,
    input  wire logic                                 reset,
    input  wire hilo_pkg::retire_slot_t [`HILO_SLOTS-1:0] i_slots,
    input  wire logic                                 i_flush,
    output hilo_pkg::hilo_ctl_t [`HILO_SLOTS-1:0]     o_ctl
);
    import hilo_pkg::*;

    retire_slot_t [`HILO_SLOTS-1:0] slots_q;

    // writeback pipeline register
    // reset or flush leaves both slots empty
    always_ff @(posedge clk) begin
        for (int i = 0; i < `HILO_SLOTS; i++) begin
            if (reset || i_flush) begin
                slots_q[i].valid <= 1'b0;
            end else begin
                slots_q[i].valid <= i_slots[i].valid;
            end
            slots_q[i].op      <= i_slots[i].op;
            slots_q[i].srca    <= i_slots[i].srca;
            slots_q[i].product <= i_slots[i].product;
        end
    end

    // per-slot decode into write enables and value source
    always_comb begin
        for (int i = 0; i < `HILO_SLOTS; i++) begin
            o_ctl[i]         = '0;
            o_ctl[i].srca    = slots_q[i].srca;
            o_ctl[i].product = slots_q[i].product;
            if (slots_q[i].valid) begin
                case (slots_q[i].op)
                    HILO_MTHI: begin
                        o_ctl[i].hi_write  = 1'b1;
                        o_ctl[i].from_srca = 1'b1;
                    end
                    HILO_MTLO: begin
                        o_ctl[i].lo_write  = 1'b1;
                        o_ctl[i].from_srca = 1'b1;
                    end
                    HILO_MULT: begin
                        o_ctl[i].hi_write = 1'b1;
                        o_ctl[i].lo_write = 1'b1;
                    end
                    HILO_MADD: begin
                        o_ctl[i].hi_write  = 1'b1;
                        o_ctl[i].lo_write  = 1'b1;
                        o_ctl[i].accum_add = 1'b1;
                    end
                    HILO_MSUB: begin
                        o_ctl[i].hi_write  = 1'b1;
                        o_ctl[i].lo_write  = 1'b1;
                        o_ctl[i].accum_sub = 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // an instruction that made it to writeback must carry a known operation
    for (genvar g = 0; g < `HILO_SLOTS; g++) begin : g_op_chk
        a_op_legal: assert property (@(posedge clk) disable iff (reset)
            slots_q[g].valid |-> slots_q[g].op inside
                {HILO_NOP, HILO_MTHI, HILO_MTLO, HILO_MULT, HILO_MADD, HILO_MSUB});
    end

endmodule

`default_nettype wire

//--- hilo/hilo_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "hilo_config.svh"

module hilo_execute (
    input  wire logic                                  clk,
    input  wire logic                                  reset,
    input  wire hilo_pkg::hilo_ctl_t [`HILO_SLOTS-1:0] i_ctl,
    input  wire hilo_pkg::word_t                       i_hi,
    input  wire hilo_pkg::word_t                       i_lo,
    output hilo_pkg::hilo_update_t                     o_update
);
    import hilo_pkg::*;

    dword_t hilo_cur;

    // both slots see the HI:LO held in the registers, not each other's result
    assign hilo_cur = {i_hi, i_lo};

    // candidate HI:LO for one slot
    // a move puts srca in both halves and the write enable picks the half
    function automatic dword_t slot_value(input hilo_ctl_t ctl, input dword_t cur);
        dword_t val;
        if (ctl.from_srca) begin
            val = {ctl.srca, ctl.srca};
        end else if (ctl.accum_add) begin
            val = cur + ctl.product;
        end else if (ctl.accum_sub) begin
            val = cur - ctl.product;
        end else begin
            val = ctl.product;
        end
        return val;
    endfunction

    always_comb begin
        word_t cand_hi;
        word_t cand_lo;
        o_update = '0;
        // older slot first, so slot 0 overwrites whatever slot 1 wrote
        for (int i = `HILO_SLOTS - 1; i >= 0; i--) begin
            {cand_hi, cand_lo} = slot_value(i_ctl[i], hilo_cur);
            if (i_ctl[i].hi_write) begin
                o_update.hi_we   = 1'b1;
                o_update.hi_data = cand_hi;
            end
            if (i_ctl[i].lo_write) begin
                o_update.lo_we   = 1'b1;
                o_update.lo_data = cand_lo;
            end
        end
    end

    // decode gives one accumulate direction at most
    for (genvar g = 0; g < `HILO_SLOTS; g++) begin : g_accum_chk
        a_accum_excl: assert property (@(posedge clk) disable iff (reset)
            !(i_ctl[g].accum_add && i_ctl[g].accum_sub));
    end

endmodule

`default_nettype wire

//--- hilo/hilo_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "hilo_config.svh"

module hilo_result (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire hilo_pkg::hilo_update_t i_update,
    output hilo_pkg::word_t             o_hi,
    output hilo_pkg::word_t             o_lo
);
    import hilo_pkg::*;

    word_t hi_q;
    word_t lo_q;

    // architectural HI with its own enable
    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= `HILO_RESET_VAL;
        end else if (i_update.hi_we) begin
            hi_q <= i_update.hi_data;
        end
    end

    // architectural LO
    always_ff @(posedge clk) begin
        if (reset) begin
            lo_q <= `HILO_RESET_VAL;
        end else if (i_update.lo_we) begin
            lo_q <= i_update.lo_data;
        end
    end

    assign o_hi = hi_q;
    assign o_lo = lo_q;

    // X on an enable would corrupt HI/LO silently
    a_we_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown({i_update.hi_we, i_update.lo_we}));

endmodule

`default_nettype wire

//--- hilo/hilo_writeback.sv
`timescale 1ns/1ps
`default_nettype none

`include "hilo_config.svh"

module hilo_writeback (
    input  wire logic                                     clk,
    input  wire logic                                     reset,
    input  wire hilo_pkg::retire_slot_t [`HILO_SLOTS-1:0] i_slots,
    input  wire logic                                     i_flush,
    output hilo_pkg::word_t                               o_hi,
    output hilo_pkg::word_t                               o_lo
);
    import hilo_pkg::*;

    hilo_ctl_t [`HILO_SLOTS-1:0] ctl;
    hilo_update_t                update;

    // writeback register and decode
    hilo_decode decode_i (
        .clk     (clk),
        .reset   (reset),
        .i_slots (i_slots),
        .i_flush (i_flush),
        .o_ctl   (ctl)
    );

    // current HI/LO fed back for accumulates
    hilo_execute execute_i (
        .clk      (clk),
        .reset    (reset),
        .i_ctl    (ctl),
        .i_hi     (o_hi),
        .i_lo     (o_lo),
        .o_update (update)
    );

    hilo_result result_i (
        .clk      (clk),
        .reset    (reset),
        .i_update (update),
        .o_hi     (o_hi),
        .o_lo     (o_lo)
    );

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
common/hilo_pkg.sv
hilo/hilo_decode.sv
hilo/hilo_execute.sv
hilo/hilo_result.sv
hilo/hilo_writeback.sv
tb/tb_hilo_writeback.sv

//--- tb/tb_hilo_writeback.sv
`timescale 1ns/1ps
`default_nettype none

`include "hilo_config.svh"

module tb_hilo_writeback;
    import hilo_pkg::*;

    localparam int clk_period      = 8;
    localparam int reset_cycles    = 5;
    localparam int directed_cycles = 60;
    localparam int n_random        = 400;
    localparam int margin_cycles   = 50;
    localparam int test_cycles     = reset_cycles + directed_cycles + n_random;

    localparam retire_slot_t no_slot = '0;

    logic                                   clk;
    logic                                   reset;
    hilo_pkg::retire_slot_t [`HILO_SLOTS-1:0] i_slots;
    logic                                   i_flush;
    word_t                                  o_hi;
    word_t                                  o_lo;

    // expected HI:LO and the last two driven pairs
    dword_t                           exp_hilo;
    retire_slot_t [`HILO_SLOTS-1:0]   hist_pair [2];
    logic                             hist_flush [2];
    logic [15:0]                      lfsr_q;
    logic                             checking;
    int                               checks;
    int                               errors;

    hilo_writeback dut_i (
        .clk     (clk),
        .reset   (reset),
        .i_slots (i_slots),
        .i_flush (i_flush),
        .o_hi    (o_hi),
        .o_lo    (o_lo)
    );

    always #(clk_period / 2) clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one LFSR step per bit
    task automatic get_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[62:0], lfsr_q[0]};
        end
    endtask

    function automatic retire_slot_t make_slot(input logic valid, input hilo_op_t op,
                                               input word_t srca, input dword_t product);
        retire_slot_t s;
        s.valid   = valid;
        s.op      = op;
        s.srca    = srca;
        s.product = product;
        return s;
    endfunction

    task automatic random_slot(output retire_slot_t s);
        logic [63:0] b;
        get_bits(1, b);
        s.valid = b[0];
        get_bits(3, b);
        s.op = hilo_op_t'(b[2:0] % 3'd6);
        get_bits(32, b);
        s.srca = b[31:0];
        get_bits(64, b);
        s.product = b;
    endtask

    // HI:LO after one retired pair
    // both slots read the old HI:LO
    function automatic dword_t ref_apply(input retire_slot_t [`HILO_SLOTS-1:0] pair,
                                         input logic fl, input dword_t cur);
        word_t new_hi;
        word_t new_lo;
        new_hi = cur[63:32];
        new_lo = cur[31:0];
        if (!fl) begin
            // older slot first so the younger overrides
            for (int s = `HILO_SLOTS - 1; s >= 0; s--) begin
                if (pair[s].valid) begin
                    case (pair[s].op)
                        HILO_MTHI: new_hi = pair[s].srca;
                        HILO_MTLO: new_lo = pair[s].srca;
                        HILO_MULT: {new_hi, new_lo} = pair[s].product;
                        HILO_MADD: {new_hi, new_lo} = cur + pair[s].product;
                        HILO_MSUB: {new_hi, new_lo} = cur - pair[s].product;
                        default: ;
                    endcase
                end
            end
        end
        return {new_hi, new_lo};
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // model steps at the edge, before the new pair goes out
    task automatic drive_pair(input retire_slot_t s1, input retire_slot_t s0, input logic fl);
        @(posedge clk);
        exp_hilo      = ref_apply(hist_pair[1], hist_flush[1], exp_hilo);
        hist_pair[1]  = hist_pair[0];
        hist_flush[1] = hist_flush[0];
        hist_pair[0]  = {s1, s0};
        hist_flush[0] = fl;
        i_slots <= {s1, s0};
        i_flush <= fl;
    endtask

    // two empty pairs push the last real pair through both stages
    task automatic drain();
        repeat (2) drive_pair(no_slot, no_slot, 1'b0);
    endtask

    task automatic expect_hilo(input word_t hi, input word_t lo);
        @(negedge clk);
        check_word("o_hi", hi, o_hi);
        check_word("o_lo", lo, o_lo);
    endtask

    always @(negedge clk) begin
        if (checking) begin
            check_word("o_hi", exp_hilo[63:32], o_hi);
            check_word("o_lo", exp_hilo[31:0], o_lo);
        end
    end

    initial begin
        #((test_cycles + margin_cycles) * clk_period);
        $display("Timeout: the run did not finish within %0d cycles",
                 test_cycles + margin_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        retire_slot_t s1;
        retire_slot_t s0;
        logic [63:0]  fbits;
        clk           = 1'b0;
        reset         = 1'b1;
        i_slots       = '0;
        i_flush       = 1'b0;
        exp_hilo      = '0;
        hist_pair[0]  = '0;
        hist_pair[1]  = '0;
        hist_flush[0] = 1'b0;
        hist_flush[1] = 1'b0;
        lfsr_q        = 16'd85;
        checking      = 1'b0;
        checks        = 0;
        errors        = 0;

        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        checking = 1'b1;
        expect_hilo(32'h0, 32'h0);

        // moves and multiply in either slot
        drive_pair(make_slot(1'b1, HILO_MTHI, 32'h1234_5678, '0), no_slot, 1'b0);
        drain();
        expect_hilo(32'h1234_5678, 32'h0);
        drive_pair(no_slot, make_slot(1'b1, HILO_MTLO, 32'h9abc_def0, '0), 1'b0);
        drain();
        expect_hilo(32'h1234_5678, 32'h9abc_def0);
        drive_pair(make_slot(1'b1, HILO_MTLO, 32'h0000_1111, '0),
                   make_slot(1'b1, HILO_MTHI, 32'h2222_0000, '0), 1'b0);
        drain();
        expect_hilo(32'h2222_0000, 32'h0000_1111);
        drive_pair(no_slot, make_slot(1'b1, HILO_MULT, 32'h5555_5555,
                                      64'h0bad_cafe_f00d_beef), 1'b0);
        drain();
        expect_hilo(32'h0bad_cafe, 32'hf00d_beef);

        // slot 0 wins when both slots write the same half
        drive_pair(make_slot(1'b1, HILO_MTHI, 32'h1111_1111, '0),
                   make_slot(1'b1, HILO_MTHI, 32'h7777_7777, '0), 1'b0);
        drain();
        expect_hilo(32'h7777_7777, 32'hf00d_beef);
        drive_pair(make_slot(1'b1, HILO_MULT, '0, 64'haaaa_aaaa_bbbb_bbbb),
                   make_slot(1'b1, HILO_MTLO, 32'hcccc_cccc, '0), 1'b0);
        drain();
        expect_hilo(32'haaaa_aaaa, 32'hcccc_cccc);

        // back-to-back accumulate with carry and borrow across the halves
        drive_pair(no_slot, make_slot(1'b1, HILO_MULT, '0, 64'h0000_0000_ffff_ffff), 1'b0);
        drive_pair(no_slot, make_slot(1'b1, HILO_MADD, '0, 64'h1), 1'b0);
        drive_pair(make_slot(1'b1, HILO_MSUB, '0, 64'h1), no_slot, 1'b0);
        drive_pair(no_slot, make_slot(1'b1, HILO_MSUB, '0, 64'h1_0000_0000), 1'b0);
        drive_pair(no_slot, make_slot(1'b1, HILO_MADD, '0, 64'h2_0000_0004), 1'b0);
        drive_pair(make_slot(1'b1, HILO_MADD, '0, 64'h5),
                   make_slot(1'b1, HILO_MSUB, '0, 64'h1), 1'b0);
        drain();
        expect_hilo(32'h0000_0002, 32'h0000_0002);

        // flushed pair and invalid slots leave HI/LO alone
        drive_pair(make_slot(1'b1, HILO_MULT, '0, '1),
                   make_slot(1'b1, HILO_MTHI, 32'hdead_beef, '0), 1'b1);
        drive_pair(no_slot, make_slot(1'b1, HILO_MTLO, 32'h0000_0005, '0), 1'b0);
        drive_pair(make_slot(1'b0, HILO_MULT, '0, '1),
                   make_slot(1'b0, HILO_MTHI, 32'hdead_beef, '0), 1'b0);
        drain();
        expect_hilo(32'h0000_0002, 32'h0000_0005);

        // random mix compared every cycle
        repeat (n_random) begin
            random_slot(s1);
            random_slot(s0);
            get_bits(3, fbits);
            drive_pair(s1, s0, fbits[2:0] == 3'd0);
        end
        drain();
        @(negedge clk);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
